// File: Makefile
# Verilator build and run for the MII receive path

VERILATOR ?= verilator
TOP       ?= tb_eth_rx
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: sim clean

# exit status of the simulation is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/eth_crc32.sv
`timescale 1ns/10ps

module eth_crc32 (
   input logic    RX_CLK,
   input logic    core_rst,
   eth_crc_if.crc crc
);
   import eth_rx_pkg::*;

   crc_t crc_q;

   // one byte, lsb first, through the reflected register
   function automatic crc_t crc_byte(input crc_t c, input byte_t d);
      crc_t next;
      int   i;
      next = c;
      for (i = 0; i < 8; i++) begin
         if (next[0] ^ d[i]) begin
            next = (next >> 1) ^ CRC_POLY;
         end else begin
            next = next >> 1;
         end
      end
      return next;
   endfunction

   always_ff @(posedge RX_CLK, posedge core_rst) begin
      if (core_rst) begin
         crc_q <= '1;
      end else if (crc.start) begin
         crc_q <= '1;
      end else if (crc.data_en) begin
         crc_q <= crc_byte(crc_q, crc.data);
      end
   end

   // bit reversed so the residue reads in normal order
   assign crc.crc_value = {<<{crc_q}};

   // engine never folds a byte while the register is being cleared
   a_start_vs_en: assert property (
      @(posedge RX_CLK) disable iff (core_rst)
      !(crc.start && crc.data_en)
   );

endmodule

// File: design/eth_crc_if.sv
`timescale 1ns/10ps

interface eth_crc_if ();
   import eth_rx_pkg::*;

   logic  start;
   byte_t data;
   logic  data_en;
   crc_t  crc_value;

   modport engine (
      output start,
      output data,
      output data_en,
      input  crc_value
   );

   modport crc (
      input  start,
      input  data,
      input  data_en,
      output crc_value
   );

endinterface

// File: design/eth_rx_buffer.sv
`timescale 1ns/10ps

module eth_rx_buffer (
   input  logic                  RX_CLK,
   input  logic                  wr,
   input  eth_rx_pkg::buf_addr_t wr_addr,
   input  eth_rx_pkg::byte_t     wr_data,
   input  eth_rx_pkg::buf_addr_t rd_addr,
   output eth_rx_pkg::byte_t     rd_data
);
   import eth_rx_pkg::*;

   byte_t mem [BUF_DEPTH];

   // byte k of the frame lands at address k
   always_ff @(posedge RX_CLK) begin
      if (wr) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // host read, one cycle latency
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: design/eth_rx_frame.sv
`timescale 1ns/10ps

module eth_rx_frame (
   input  logic                  RX_CLK,
   input  logic                  core_rst,
   input  logic                  RX_DV,
   input  eth_rx_pkg::nibble_t   RX_DATA,
   input  eth_rx_pkg::len_t      nbytes_sync,
   input  logic                  ack_sync,
   eth_crc_if.engine             crc,
   output logic                  wr,
   output eth_rx_pkg::buf_addr_t wr_addr,
   output eth_rx_pkg::byte_t     wr_data,
   output logic                  data_rcvd
);
   import eth_rx_pkg::*;

   rx_state_e state;
   byte_t     shift_q;
   byte_t     rx_byte;
   logic      phase;
   buf_addr_t byte_cnt;
   buf_addr_t last_idx;
   mac_addr_t dest_q;
   mac_addr_t dest_next;

   // low nibble arrives first, new nibble goes on top
   assign rx_byte   = {RX_DATA, shift_q[7:4]};
   assign dest_next = {dest_q[39:0], rx_byte};
   assign last_idx  = buf_addr_t'(HDR_BYTES + FCS_BYTES - 1) + nbytes_sync;

   always_ff @(posedge RX_CLK) begin
      if (RX_DV) begin
         shift_q <= rx_byte;
      end
      if (state == DEST_ADDR && RX_DV && phase) begin
         dest_q <= dest_next;
      end
   end

   always_ff @(posedge RX_CLK, posedge core_rst) begin
      if (core_rst) begin
         state     <= WAIT_SFD;
         phase     <= 1'b0;
         byte_cnt  <= '0;
         wr        <= 1'b0;
         wr_addr   <= '0;
         data_rcvd <= 1'b0;
      end else begin
         wr <= 1'b0;
         case (state)
            WAIT_SFD: begin
               phase    <= 1'b0;
               byte_cnt <= '0;
               if (RX_DV && rx_byte == SFD_BYTE) begin
                  state <= DEST_ADDR;
               end
            end
            DEST_ADDR, BODY: begin
               if (!RX_DV) begin
                  // carrier lost mid-frame
                  state <= WAIT_SFD;
               end else begin
                  phase <= ~phase;
                  if (phase) begin
                     wr_addr  <= byte_cnt;
                     byte_cnt <= byte_cnt + 1'b1;
                     wr       <= 1'b1;
                     if (state == DEST_ADDR) begin
                        if (byte_cnt == buf_addr_t'(MAC_BYTES - 1)) begin
                           if (dest_next == STATION_MAC) begin
                              state <= BODY;
                           end else begin
                              // not ours, drop without writing
                              state <= WAIT_SFD;
                              wr    <= 1'b0;
                           end
                        end
                     end else if (byte_cnt == last_idx) begin
                        state <= CHECK;
                     end
                  end
               end
            end
            CHECK: begin
               // last fcs byte folds while wr is still up
               if (!wr) begin
                  if (crc.crc_value == CRC_RESIDUE) begin
                     state     <= HOLD;
                     data_rcvd <= 1'b1;
                  end else begin
                     state <= WAIT_SFD;
                  end
               end
            end
            HOLD: begin
               // MII ignored until the host has read the frame
               if (ack_sync) begin
                  state     <= WAIT_SFD;
                  data_rcvd <= 1'b0;
               end
            end
            default: begin
               state <= WAIT_SFD;
            end
         endcase
      end
   end

   assign wr_data     = shift_q;
   assign crc.start   = (state == WAIT_SFD);
   assign crc.data    = shift_q;
   assign crc.data_en = wr;

   a_no_wr_idle: assert property (
      @(posedge RX_CLK) disable iff (core_rst)
      (state == WAIT_SFD || state == HOLD) |-> !wr
   );

   // whole frame fits the buffer and writes stay inside the current frame
   a_wr_range: assert property (
      @(posedge RX_CLK) disable iff (core_rst)
      wr |-> (int'(nbytes_sync) + HDR_BYTES + FCS_BYTES <= BUF_DEPTH && wr_addr <= last_idx)
   );

   a_rcvd_hold: assert property (
      @(posedge RX_CLK) disable iff (core_rst)
      data_rcvd |-> state == HOLD
   );

endmodule

// File: design/eth_rx_pkg.sv
package eth_rx_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;
   typedef logic [10:0] buf_addr_t;
   typedef logic [10:0] len_t;
   typedef logic [47:0] mac_addr_t;
   typedef logic [31:0] crc_t;

   // first address byte on the wire is the top byte
   localparam mac_addr_t STATION_MAC = 48'h00_01_02_03_04_05;

   localparam byte_t SFD_BYTE = 8'hD5;

   // residue in normal bit order after a good FCS
   localparam crc_t CRC_RESIDUE = 32'hC704DD7B;
   // reflected form of the ethernet polynomial
   localparam crc_t CRC_POLY = 32'hEDB88320;

   localparam int MAC_BYTES = 6;
   localparam int HDR_BYTES = 14;
   localparam int FCS_BYTES = 4;
   localparam int BUF_DEPTH = 2048;

   typedef enum logic [2:0] {
      WAIT_SFD,
      DEST_ADDR,
      BODY,
      CHECK,
      HOLD
   } rx_state_e;

endpackage

// File: design/eth_rx_sync.sv
`timescale 1ns/10ps

module eth_rx_sync (
   input  logic             RX_CLK,
   input  logic             rx_rst,
   input  logic             rcv_ack,
   input  eth_rx_pkg::len_t nbytes,
   output logic             core_rst,
   output logic             ack_sync,
   output eth_rx_pkg::len_t nbytes_sync
);
   import eth_rx_pkg::*;

   logic [1:0] rst_q;
   logic       ack_meta;
   len_t       nbytes_meta;

   // asserts at once, releases two edges later
   always_ff @(posedge RX_CLK, posedge rx_rst) begin
      if (rx_rst) begin
         rst_q <= 2'b11;
      end else begin
         rst_q <= {rst_q[0], 1'b0};
      end
   end

   assign core_rst = rst_q[1];

   // preset by the ack itself so a short pulse still lands
   always_ff @(posedge RX_CLK, posedge rcv_ack) begin
      if (rcv_ack) begin
         ack_meta <= 1'b1;
      end else begin
         ack_meta <= 1'b0;
      end
   end

   always_ff @(posedge RX_CLK, posedge rx_rst) begin
      if (rx_rst) begin
         ack_sync <= 1'b0;
      end else begin
         ack_sync <= ack_meta;
      end
   end

   // host keeps nbytes steady for the whole frame
   always_ff @(posedge RX_CLK) begin
      nbytes_meta <= nbytes;
      nbytes_sync <= nbytes_meta;
   end

endmodule

// File: design/eth_rx_top.sv
`timescale 1ns/10ps

module eth_rx_top (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  RX_DV,
   input  eth_rx_pkg::nibble_t   RX_DATA,
   input  eth_rx_pkg::len_t      nbytes,
   input  logic                  rcv_ack,
   input  eth_rx_pkg::buf_addr_t rd_addr,
   output logic                  data_rcvd,
   output eth_rx_pkg::byte_t     rd_data
);
   import eth_rx_pkg::*;

   logic      core_rst;
   logic      ack_sync;
   len_t      nbytes_sync;
   logic      wr;
   buf_addr_t wr_addr;
   byte_t     wr_data;

   eth_crc_if crc_bus ();

   eth_rx_sync u_sync (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rcv_ack     (rcv_ack),
      .nbytes      (nbytes),
      .core_rst    (core_rst),
      .ack_sync    (ack_sync),
      .nbytes_sync (nbytes_sync)
   );

   eth_rx_frame u_frame (
      .RX_CLK      (RX_CLK),
      .core_rst    (core_rst),
      .RX_DV       (RX_DV),
      .RX_DATA     (RX_DATA),
      .nbytes_sync (nbytes_sync),
      .ack_sync    (ack_sync),
      .crc         (crc_bus.engine),
      .wr          (wr),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .data_rcvd   (data_rcvd)
   );

   eth_crc32 u_crc (
      .RX_CLK   (RX_CLK),
      .core_rst (core_rst),
      .crc      (crc_bus.crc)
   );

   eth_rx_buffer u_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: list.f
design/eth_rx_pkg.sv
design/eth_crc_if.sv
design/eth_rx_sync.sv
design/eth_crc32.sv
design/eth_rx_frame.sv
design/eth_rx_buffer.sv
design/eth_rx_top.sv
verif/tb_eth_rx.sv

// File: verif/eth_rx_golden.txt
// act nbytes bad seed, then dest(6) src(6) type(2), every field in hex
// act 1 kept, 2 dropped, 3 sent while a frame is held, 4 reset mid-frame

// shortest payload to this station
1 002E 0 11  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

// last address byte differs
2 0040 0 22  00 01 02 03 04 06  00 0A 0B 0C 0D 0E  08 00

// good frame after the foreign one
1 0064 0 33  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 06

// payload byte 5 flipped after the fcs was formed
2 0064 1 44  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

// good frame after the bad fcs
1 002E 0 55  00 01 02 03 04 05  00 1A 2B 3C 4D 5E  08 00

// full size payload
1 05DC 0 66  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

// arrives before the host has acked the big frame
3 003C 0 77  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

// cut short by rx_rst
4 0040 0 88  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

// recovery after the reset
1 0064 0 99  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  08 00

1 002E 0 AA  00 01 02 03 04 05  00 0A 0B 0C 0D 0E  88 B5

// end of records
0

// File: verif/tb_eth_rx.sv
`timescale 1ns/10ps

module tb_eth_rx;
   import eth_rx_pkg::*;

   localparam int MAX_RECS  = 32;
   localparam int REC_WORDS = 18;
   localparam int MAX_FRAME = 1536;

   // action codes in the golden file
   localparam int ACT_KEPT  = 1;
   localparam int ACT_DROP  = 2;
   localparam int ACT_HELD  = 3;
   localparam int ACT_RESET = 4;

   logic      RX_CLK;
   logic      rx_rst;
   logic      RX_DV;
   nibble_t   RX_DATA;
   len_t      nbytes;
   logic      rcv_ack;
   buf_addr_t rd_addr;
   logic      data_rcvd;
   byte_t     rd_data;

   logic [15:0] gold [REC_WORDS*MAX_RECS];
   byte_t       frame [MAX_FRAME];
   byte_t       held_frame [MAX_FRAME];
   int          frame_len;
   int          held_len;
   logic        held;
   int          seed;
   int          budget;
   logic        budget_ready;

   eth_rx_top DUT (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .RX_DV     (RX_DV),
      .RX_DATA   (RX_DATA),
      .nbytes    (nbytes),
      .rcv_ack   (rcv_ack),
      .rd_addr   (rd_addr),
      .data_rcvd (data_rcvd),
      .rd_data   (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   // watchdog starts once the golden file has been sized
   initial begin
      wait (budget_ready);
      #(budget * 10);
      $display("timeout: run did not finish within %0d cycles", budget);
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

   task automatic tick();
      @(posedge RX_CLK);
      #1;
   endtask

   task automatic abort_run(input string why);
      $display("%s at %0t", why, $time);
      $display("TESTBENCH FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // ethernet fcs with a shift register in wire bit order
   function automatic logic [31:0] wire_crc(input int len);
      logic [31:0] c;
      logic        fb;
      int          k;
      int          i;
      c = 32'hFFFF_FFFF;
      for (k = 0; k < len; k++) begin
         for (i = 0; i < 8; i++) begin
            fb = c[31] ^ frame[k][i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
               c = c ^ 32'h04C1_1DB7;
            end
         end
      end
      return ~c;
   endfunction

   task automatic build_frame(input int base);
      int          n;
      int          k;
      int          i;
      logic [31:0] f;
      byte_t       s;
      n = int'(gold[base + 1]);
      s = byte_t'(gold[base + 3]);
      frame_len = HDR_BYTES + n + FCS_BYTES;
      for (k = 0; k < HDR_BYTES; k++) begin
         frame[k] = byte_t'(gold[base + 4 + k]);
      end
      // payload pattern uses every bit of the index
      for (k = 0; k < n; k++) begin
         frame[HDR_BYTES + k] = byte_t'(k * 7) ^ byte_t'(k >> 8) ^ s;
      end
      f = wire_crc(HDR_BYTES + n);
      // first bit on the wire is the top fcs bit
      for (k = 0; k < FCS_BYTES; k++) begin
         for (i = 0; i < 8; i++) begin
            frame[HDR_BYTES + n + k][i] = f[31 - 8*k - i];
         end
      end
      if (gold[base + 2] != 16'h0) begin
         frame[HDR_BYTES + 5] = frame[HDR_BYTES + 5] ^ 8'h40;
      end
   endtask

   task automatic put_nibble(input nibble_t d);
      RX_DV   = 1'b1;
      RX_DATA = d;
      tick();
   endtask

   // preamble, sfd, then the first count bytes low nibble first
   task automatic drive_frame(input int count);
      int k;
      for (k = 0; k < 7; k++) begin
         put_nibble(4'h5);
         put_nibble(4'h5);
      end
      put_nibble(SFD_BYTE[3:0]);
      put_nibble(SFD_BYTE[7:4]);
      for (k = 0; k < count; k++) begin
         put_nibble(frame[k][3:0]);
         put_nibble(frame[k][7:4]);
      end
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
   endtask

   task automatic idle(input int cycles);
      RX_DV   = 1'b0;
      RX_DATA = 4'h0;
      repeat (cycles) tick();
   endtask

   task automatic check_level(input logic exp, input int cycles);
      int c;
      for (c = 0; c < cycles; c++) begin
         tick();
         compare("data_rcvd", 32'(data_rcvd), 32'(exp));
      end
   endtask

   task automatic wait_rcvd();
      int c;
      c = 0;
      while (!data_rcvd && c < 6) begin
         tick();
         c++;
      end
      if (!data_rcvd) begin
         abort_run("data_rcvd did not rise within 6 cycles after the frame");
      end
   endtask

   task automatic read_back();
      int k;
      for (k = 0; k < held_len; k++) begin
         rd_addr = buf_addr_t'(k);
         tick();
         compare($sformatf("rd_data[%0d]", k), 32'(rd_data), 32'(held_frame[k]));
      end
   endtask

   task automatic pulse_ack();
      int c;
      rcv_ack = 1'b1;
      tick();
      rcv_ack = 1'b0;
      c = 0;
      while (data_rcvd && c < 4) begin
         tick();
         c++;
      end
      if (data_rcvd) begin
         abort_run("data_rcvd still high 4 cycles after rcv_ack");
      end
      held = 1'b0;
      // nothing sent during the hold may come back
      check_level(1'b0, 20);
   endtask

   initial begin
      int r;
      int k;
      int base;
      int act;
      int len;
      int nrec;
      int gap;
      budget_ready = 1'b0;
      seed     = 31420;
      rx_rst   = 1'b1;
      RX_DV    = 1'b0;
      RX_DATA  = 4'h0;
      nbytes   = '0;
      rcv_ack  = 1'b0;
      rd_addr  = '0;
      held     = 1'b0;
      held_len = 0;
      for (k = 0; k < REC_WORDS*MAX_RECS; k++) begin
         gold[k] = 16'h0;
      end
      $readmemh("verif/eth_rx_golden.txt", gold);

      // nibbles, up to two buffer reads and a margin per record
      budget = 20;
      nrec   = 0;
      while (nrec < MAX_RECS && gold[nrec*REC_WORDS] != 16'h0) begin
         len    = HDR_BYTES + int'(gold[nrec*REC_WORDS + 1]) + FCS_BYTES;
         budget = budget + 16 + 4*len + 200;
         nrec++;
      end
      if (nrec == 0) begin
         abort_run("golden file holds no records");
      end
      budget_ready = 1'b1;

      repeat (5) tick();
      rx_rst = 1'b0;
      check_level(1'b0, 4);

      for (r = 0; r < nrec; r++) begin
         base = r * REC_WORDS;
         act  = int'(gold[base]);
         if (held && act != ACT_HELD) begin
            pulse_ack();
         end
         build_frame(base);
         nbytes = len_t'(gold[base + 1]);
         gap = 12 + ($unsigned($random(seed)) % 8);
         idle(gap);
         case (act)
            ACT_KEPT: begin
               drive_frame(frame_len);
               wait_rcvd();
               for (k = 0; k < frame_len; k++) begin
                  held_frame[k] = frame[k];
               end
               held_len = frame_len;
               held     = 1'b1;
               read_back();
            end
            ACT_DROP: begin
               drive_frame(frame_len);
               check_level(1'b0, 20);
            end
            ACT_HELD: begin
               if (!held) begin
                  abort_run("golden file sends a held frame while no frame is held");
               end
               drive_frame(frame_len);
               check_level(1'b1, 20);
               read_back();
            end
            ACT_RESET: begin
               // good frame sent in full, rx_rst rises halfway and stays up past its end
               fork
                  drive_frame(frame_len);
                  begin
                     repeat (16 + frame_len) tick();
                     rx_rst = 1'b1;
                  end
               join
               check_level(1'b0, 5);
               rx_rst = 1'b0;
               check_level(1'b0, 20);
            end
            default: begin
               abort_run($sformatf("unknown action code %0d in golden file", act));
            end
         endcase
      end
      if (held) begin
         pulse_ack();
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
